// File: hw/sdSpiDefs.svh
// shared widths and bit positions; the control word sits in the low 32 bits of the 64-bit bus word
`ifndef SD_SPI_DEFS_SVH
`define SD_SPI_DEFS_SVH

// bus widths
`define DATA_W 64
`define ADDR_W 32
`define SELF_W 12

// register offsets, taken from address bits 3:2
`define REG_CTRL 2'd0
`define REG_DATA 2'd1
`define REG_QUEUE 2'd2

// control word bits
`define CTRL_CS 0
// start one byte on write, busy flag on read
`define CTRL_XMIT1 1
`define CTRL_XMIT8 5
// clock divider field
`define CTRL_DIV 31:24

// reload count is {2'b00, divider, DIV_LOW_BITS}
`define DIV_W 14
`define DIV_LOW_BITS 4'hA

// bytes per burst
`define BURST_BYTES 8

`endif

// File: hw/sdSpiPkg.sv
// only bits 3 (read) and 4 (write) of an operation are decoded; the size bits are ignored
package sdSpiPkg;

	// response code returned on mmioOK
	// ready when idle or not addressed
	// hold while the request is still in progress
	// ok once the request has completed
	typedef enum logic [1:0]
	{
		ready = 2'b00,
		ok = 2'b01,
		hold = 2'b10
	} mmioOk;

	// bus operation code
	// low bits carry the access size, which this block does not look at
	typedef enum logic [4:0]
	{
		opNone = 5'b00000,
		opRead = 5'b01011,
		opWrite = 5'b10011
	} mmioOp;

	// decoded operation bits
	localparam int opReadBit = 3;
	localparam int opWriteBit = 4;

endpackage

// File: hw/spiEngineIf.sv
// start is a one-cycle pulse issued only while busy is low; rxByte holds from done until the next start
`timescale 1ns/1ns
`include "sdSpiDefs.svh"

interface spiEngineIf;

	// host side to engine
	logic start;
	logic [7:0] txByte;
	logic [`DIV_W-1:0] divReload;
	logic csLevel;

	// engine side back to host
	logic busy;
	logic [7:0] rxByte;
	logic done;

	// register block view
	modport host
	(
		output start, txByte, divReload, csLevel,
		input busy, rxByte, done
	);

	// bit engine view
	modport engine
	(
		input start, txByte, divReload, csLevel,
		output busy, rxByte, done
	);

endinterface

// File: hw/mmioSpiRegs.sv
// master holds each request until ok and idles a cycle between requests; a new start needs a read first
`timescale 1ns/1ns
`include "sdSpiDefs.svh"

module mmioSpiRegs
	import sdSpiPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [`DATA_W-1:0] mmioInData,
	output logic [`DATA_W-1:0] mmioOutData,
	input logic [`ADDR_W-1:0] mmioAddr,
	input mmioOp mmioOpm,
	output mmioOk mmioOK,
	input logic [`SELF_W-1:0] mmioSelfAddr,
	spiEngineIf.host engine
);

	// registered bus request
	logic [`DATA_W-1:0] inData;
	logic [`ADDR_W-1:0] addr;
	logic [4:0] opm;

	// registered response
	logic [`DATA_W-1:0] outData;
	mmioOk okReg;

	// programmer visible state
	logic [31:0] ctrlReg;
	logic [`DATA_W-1:0] sendQ;
	logic [`DATA_W-1:0] recvQ;
	logic [7:0] txReg;

	// sequencing
	logic [3:0] byteCnt;
	logic startReg;
	logic latchWr;
	logic xmitDeb;

	// decode and next response
	logic selfSel;
	logic rdSel;
	logic wrSel;
	logic [1:0] regOff;
	logic xferBusy;
	mmioOk respOk;
	logic [`DATA_W-1:0] respData;
	logic wrApply;
	logic rdClear;

	// device select from the registered address
	assign selfSel = (addr[27:16] == 12'h000) && (addr[15:4] == mmioSelfAddr);
	assign rdSel = selfSel && opm[opReadBit];
	assign wrSel = selfSel && opm[opWriteBit];
	assign regOff = addr[3:2];

	// covers the start pulse, the engine run and the gaps inside a burst
	assign xferBusy = startReg || engine.busy || (byteCnt != 4'd0);

	always_comb
	begin
		respOk = ready;
		respData = '0;
		wrApply = 1'b0;
		rdClear = 1'b0;
		if (rdSel)
		begin
			// any read re-arms the start debounce
			rdClear = 1'b1;
			respOk = ok;
			case (regOff)
				`REG_CTRL:
				begin
					respData = {32'h0, ctrlReg};
					respData[`CTRL_XMIT1] = xferBusy;
				end
				`REG_DATA:
				begin
					// received byte only once the transfer is over
					if (xferBusy)
						respOk = hold;
					else
						respData = {56'h0, engine.rxByte};
				end
				`REG_QUEUE:
					respData = recvQ;
				default:
					respData = '0;
			endcase
		end
		else if (wrSel)
		begin
			// second cycle of an applied write
			if (latchWr)
				respOk = ok;
			// wait for the transfer to finish
			else if (xferBusy)
				respOk = hold;
			else
			begin
				respOk = hold;
				wrApply = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		inData <= mmioInData;
		addr <= mmioAddr;
		outData <= respData;
		if (reset)
		begin
			opm <= opNone;
			okReg <= ready;
			ctrlReg <= 32'h0000_0001;
			byteCnt <= 4'd0;
			startReg <= 1'b0;
			latchWr <= 1'b0;
			xmitDeb <= 1'b0;
		end
		else
		begin
			opm <= mmioOpm;
			okReg <= respOk;
			startReg <= 1'b0;
			// stays set while the same write is still presented
			latchWr <= wrSel && (latchWr || wrApply);
			if (rdClear)
				xmitDeb <= 1'b0;
			if (wrApply)
			begin
				case (regOff)
					`REG_CTRL:
					begin
						ctrlReg <= inData[31:0];
						// single byte wins over burst
						if (!xmitDeb && inData[`CTRL_XMIT1])
						begin
							startReg <= 1'b1;
							xmitDeb <= 1'b1;
						end
						else if (!xmitDeb && inData[`CTRL_XMIT8])
						begin
							startReg <= 1'b1;
							xmitDeb <= 1'b1;
							byteCnt <= 4'(`BURST_BYTES);
							txReg <= sendQ[7:0];
						end
					end
					`REG_DATA:
						txReg <= inData[7:0];
					`REG_QUEUE:
						sendQ <= inData;
					default:
						;
				endcase
			end
			// burst step on each finished byte
			if (engine.done && (byteCnt != 4'd0))
			begin
				sendQ <= {8'hFF, sendQ[`DATA_W-1:8]};
				recvQ <= {engine.rxByte, recvQ[`DATA_W-1:8]};
				byteCnt <= byteCnt - 4'd1;
				// next byte goes out one cycle after done
				if (byteCnt != 4'd1)
				begin
					startReg <= 1'b1;
					txReg <= sendQ[15:8];
				end
			end
		end
	end

	// engine side
	assign engine.start = startReg;
	assign engine.txByte = txReg;
	assign engine.divReload = {2'b00, ctrlReg[`CTRL_DIV], `DIV_LOW_BITS};
	assign engine.csLevel = ctrlReg[`CTRL_CS];

	// bus side
	assign mmioOutData = outData;
	assign mmioOK = okReg;

endmodule

// File: hw/spiBitEngine.sv
// SPI mode 0, MSB first, one byte per start; divReload is taken at start and must be at least 2
`timescale 1ns/1ns
`include "sdSpiDefs.svh"

module spiBitEngine
(
	input logic clock,
	input logic reset,
	input logic spiMiso,
	output logic spiSclk,
	output logic spiMosi,
	output logic spiCs,
	spiEngineIf.engine link
);

	// bit timing
	logic [`DIV_W-1:0] reload;
	logic [`DIV_W-1:0] divCnt;
	logic [`DIV_W-1:0] divHalf;
	// periods still to run after the current one
	logic [2:0] bitsLeft;

	// data path
	logic [7:0] txShift;
	logic [7:0] rxShift;
	logic misoSync;

	// registered pins and status
	logic sclkReg;
	logic mosiReg;
	logic csReg;
	logic busyReg;
	logic doneReg;

	// rising point inside a bit period
	assign divHalf = {1'b0, reload[`DIV_W-1:1]};

	// one stage towards the clock domain
	always_ff @(posedge clock)
	begin
		misoSync <= spiMiso;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busyReg <= 1'b0;
			doneReg <= 1'b0;
			bitsLeft <= 3'd0;
			divCnt <= '0;
			sclkReg <= 1'b0;
			mosiReg <= 1'b1;
			csReg <= 1'b1;
		end
		else
		begin
			doneReg <= 1'b0;
			csReg <= link.csLevel;
			if (!busyReg)
			begin
				// first period begins on the start edge
				if (link.start)
				begin
					busyReg <= 1'b1;
					reload <= link.divReload;
					divCnt <= link.divReload;
					sclkReg <= 1'b0;
					mosiReg <= link.txByte[7];
					txShift <= {link.txByte[6:0], 1'b0};
					bitsLeft <= 3'd7;
				end
			end
			else if (divCnt != '0)
			begin
				divCnt <= divCnt - 1'b1;
				// SCLK rises and MISO is taken
				if (divCnt == divHalf)
				begin
					sclkReg <= 1'b1;
					rxShift <= {rxShift[6:0], misoSync};
				end
			end
			else if (bitsLeft != 3'd0)
			begin
				// period boundary, SCLK falls with the new MOSI bit
				divCnt <= reload;
				sclkReg <= 1'b0;
				mosiReg <= txShift[7];
				txShift <= {txShift[6:0], 1'b0};
				bitsLeft <= bitsLeft - 3'd1;
			end
			else
			begin
				// eighth period over
				busyReg <= 1'b0;
				doneReg <= 1'b1;
				sclkReg <= 1'b0;
			end
		end
	end

	// status back to the register block
	assign link.busy = busyReg;
	assign link.done = doneReg;
	assign link.rxByte = rxShift;

	// pins
	assign spiSclk = sclkReg;
	assign spiMosi = mosiReg;
	assign spiCs = csReg;

endmodule

// File: hw/sdSpiTop.sv
// one card on one chip select; no command framing, interrupt or DMA, bus and pins are plain ports
`timescale 1ns/1ns
`include "sdSpiDefs.svh"

module sdSpiTop
	import sdSpiPkg::*;
(
	input logic clock,
	input logic reset,
	// memory mapped bus
	input logic [`DATA_W-1:0] mmioInData,
	output logic [`DATA_W-1:0] mmioOutData,
	input logic [`ADDR_W-1:0] mmioAddr,
	input mmioOp mmioOpm,
	output mmioOk mmioOK,
	input logic [`SELF_W-1:0] mmioSelfAddr,
	// card pins
	output logic spiSclk,
	output logic spiMosi,
	output logic spiCs,
	input logic spiMiso
);

	// link between register block and bit engine
	spiEngineIf engineLink ();

	// bus front end and transfer sequencing
	mmioSpiRegs regs0
	(
		.clock(clock),
		.reset(reset),
		.mmioInData(mmioInData),
		.mmioOutData(mmioOutData),
		.mmioAddr(mmioAddr),
		.mmioOpm(mmioOpm),
		.mmioOK(mmioOK),
		.mmioSelfAddr(mmioSelfAddr),
		.engine(engineLink.host)
	);

	// serial clock, data and chip select
	spiBitEngine engine0
	(
		.clock(clock),
		.reset(reset),
		.spiMiso(spiMiso),
		.spiSclk(spiSclk),
		.spiMosi(spiMosi),
		.spiCs(spiCs),
		.link(engineLink.engine)
	);

endmodule

// File: verification/clockGen.sv
// free-running clock from time zero; reset is high at start and drops on a falling edge
`timescale 1ns/1ns

module clockGen
#(
	parameter int periodNs = 8,
	parameter int resetCycles = 4
)
(
	output logic clock,
	output logic reset
);

	// half period per toggle
	initial
	begin
		clock = 1'b0;
		forever
			#(periodNs / 2) clock = ~clock;
	end

	// reset held for the given number of rising edges
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

// File: verification/spiCardModel.sv
// mode 0 card stand-in; ignores CS, answers FF when its response queue runs dry, clear it while idle
`timescale 1ns/1ns

module spiCardModel
(
	input logic spiSclk,
	input logic spiMosi,
	output logic spiMiso
);

	// bytes still to send, front byte goes out first
	logic [7:0] respQ [$];
	// bytes seen on MOSI in arrival order
	logic [7:0] mosiLog [$];

	int outBits;
	int inBits;
	logic [7:0] inShift;
	logic misoReg;

	assign spiMiso = misoReg;

	// current bit of the front byte, MSB first
	task automatic driveBit();
		logic [7:0] cur;
		cur = (respQ.size() > 0) ? respQ[0] : 8'hFF;
		misoReg = cur[7 - outBits];
	endtask

	task automatic queueByte(input logic [7:0] b);
		respQ.push_back(b);
		driveBit();
	endtask

	// empty both queues and restart bit counts
	task automatic clearLogs();
		respQ.delete();
		mosiLog.delete();
		outBits = 0;
		inBits = 0;
		driveBit();
	endtask

	// MOSI taken on the rising edge
	always @(posedge spiSclk)
	begin
		inShift = {inShift[6:0], spiMosi};
		inBits = inBits + 1;
		if (inBits == 8)
		begin
			mosiLog.push_back(inShift);
			inBits = 0;
		end
	end

	// next MISO bit after each falling edge
	always @(negedge spiSclk)
	begin
		outBits = outBits + 1;
		// byte finished, move to the next one
		if (outBits == 8)
		begin
			if (respQ.size() > 0)
				void'(respQ.pop_front());
			outBits = 0;
		end
		driveBit();
	end

	initial
	begin
		outBits = 0;
		inBits = 0;
		misoReg = 1'b1;
	end

endmodule

// File: verification/sdSpiChk.sv
// assumes the master idles between requests, keeps the address while held and fixes mmioSelfAddr
`timescale 1ns/1ns

module sdSpiChk
	import sdSpiPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [31:0] mmioAddr,
	input logic [11:0] mmioSelfAddr,
	input mmioOk mmioOK,
	input logic spiSclk,
	input logic spiCs
);

	// failed assertion count
	int assertFails = 0;

	// chip select only moves while SCLK is low
	csQuiet: assert property (@(posedge clock) disable iff (reset)
		(spiCs != $past(spiCs)) |-> !spiSclk)
	else
	begin
		assertFails++;
		$error("SCLK was high in the cycle chip select changed");
	end

	// ok belongs to the request sampled two edges earlier
	okAddressed: assert property (@(posedge clock) disable iff (reset)
		(mmioOK == ok) |-> (($past(mmioAddr[27:16], 2) == 12'h000)
			&& ($past(mmioAddr[15:4], 2) == mmioSelfAddr)))
	else
	begin
		assertFails++;
		$error("ok response given to an unaddressed request");
	end

	// once ok, a request never falls back to hold
	noHoldAfterOk: assert property (@(posedge clock) disable iff (reset)
		(mmioOK == ok) |=> (mmioOK != hold))
	else
	begin
		assertFails++;
		$error("hold response followed ok for the same request");
	end

endmodule

bind sdSpiTop sdSpiChk chk0
(
	.clock(clock),
	.reset(reset),
	.mmioAddr(mmioAddr),
	.mmioSelfAddr(mmioSelfAddr),
	.mmioOK(mmioOK),
	.spiSclk(spiSclk),
	.spiCs(spiCs)
);

// File: verification/sdSpiTb.sv
// fixed device select; random divider limited to the low nibble to keep bit times short
`timescale 1ns/1ns
`include "sdSpiDefs.svh"

module sdSpiTb
	import sdSpiPkg::*;
();

	localparam int clkPeriod = 8;
	localparam int numSingles = 12;
	localparam int numBursts = 4;
	// singles, bursts, the busy test and some spare
	localparam int numBytes = numSingles + 8 * numBursts + 16;
	// slowest byte at divider 15 plus bus overhead
	localparam int maxReload = 15 * 16 + 10;
	localparam int byteCycles = 8 * (maxReload + 1) + 40;
	localparam int busLimit = 8 * byteCycles + 100;
	localparam int pollLimit = 2 * byteCycles;
	localparam logic [11:0] selfAddr = 12'h3A5;

	logic clock;
	logic reset;
	logic [63:0] mmioInData;
	logic [63:0] mmioOutData;
	logic [31:0] mmioAddr;
	mmioOp mmioOpm;
	mmioOk mmioOK;
	logic [11:0] mmioSelfAddr;
	logic spiSclk;
	logic spiMosi;
	logic spiCs;
	logic spiMiso;

	logic [31:0] lfsrState;
	int errors;
	int checks;
	// control word as it should read back when idle
	logic [31:0] expCtrl;
	// receive queue after the last burst
	logic [63:0] expQueue;
	longint riseTimes [$];

	clockGen #(.periodNs(clkPeriod), .resetCycles(4)) clk0
	(
		.clock(clock),
		.reset(reset)
	);

	sdSpiTop dut0
	(
		.clock(clock),
		.reset(reset),
		.mmioInData(mmioInData),
		.mmioOutData(mmioOutData),
		.mmioAddr(mmioAddr),
		.mmioOpm(mmioOpm),
		.mmioOK(mmioOK),
		.mmioSelfAddr(mmioSelfAddr),
		.spiSclk(spiSclk),
		.spiMosi(spiMosi),
		.spiCs(spiCs),
		.spiMiso(spiMiso)
	);

	spiCardModel card0
	(
		.spiSclk(spiSclk),
		.spiMosi(spiMosi),
		.spiMiso(spiMiso)
	);

	// SCLK rise times for period checks
	always @(posedge spiSclk)
		riseTimes.push_back($time);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one LFSR step per bit, result right aligned
	function automatic logic [63:0] takeBits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[62:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] regAddr(input logic [1:0] off);
		return {4'h0, 12'h000, selfAddr, off, 2'b00};
	endfunction

	task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// one bus request held until ok, then a few idle cycles
	task automatic busAccess(input mmioOp op, input logic [31:0] addr, input logic [63:0] data,
		output logic [63:0] rdata);
		int waitCycles;
		waitCycles = 0;
		@(negedge clock);
		mmioAddr = addr;
		mmioInData = data;
		mmioOpm = op;
		@(negedge clock);
		while (mmioOK != ok && waitCycles < busLimit)
		begin
			@(negedge clock);
			waitCycles++;
		end
		rdata = mmioOutData;
		if (mmioOK != ok)
		begin
			errors++;
			$display("bus request to address %h never got an ok response", addr);
		end
		mmioOpm = opNone;
		// held response drains before the next request
		repeat (3) @(negedge clock);
	endtask

	// poll status until busy clears
	task automatic waitIdle();
		logic [63:0] st;
		int polls;
		polls = 0;
		busAccess(opRead, regAddr(`REG_CTRL), 64'h0, st);
		// first poll always lands inside the transfer
		checkValue("status while busy", st, {32'h0, expCtrl | 32'h2});
		while (st[`CTRL_XMIT1] && polls < pollLimit)
		begin
			busAccess(opRead, regAddr(`REG_CTRL), 64'h0, st);
			polls++;
		end
		checkValue("status after transfer", st, {32'h0, expCtrl});
	endtask

	// bit period is divReload+1 clocks, divReload being the divider then 4'hA
	task automatic checkRisePeriods(input logic [3:0] div);
		longint expPeriod;
		expPeriod = (longint'(div) * 16 + 10 + 1) * clkPeriod;
		checkValue("SCLK rising edges per byte", riseTimes.size(), 8);
		for (int i = 1; i < riseTimes.size(); i++)
			checkValue("SCLK period in ns", riseTimes[i] - riseTimes[i - 1], expPeriod);
	endtask

	task automatic singleTest();
		logic [7:0] txByte;
		logic [7:0] cardByte;
		logic [3:0] div;
		logic csBit;
		logic [31:0] ctrl;
		logic [63:0] rd;
		txByte = 8'(takeBits(8));
		cardByte = 8'(takeBits(8));
		div = 4'(takeBits(4));
		csBit = 1'(takeBits(1));
		// random spare bits, burst bit clear, single start set
		ctrl = {4'h0, div, 18'(takeBits(18)), 1'b0, 3'(takeBits(3)), 1'b1, csBit};
		card0.clearLogs();
		card0.queueByte(cardByte);
		riseTimes.delete();
		busAccess(opWrite, regAddr(`REG_DATA), {56'(takeBits(56)), txByte}, rd);
		expCtrl = ctrl & ~32'h2;
		busAccess(opWrite, regAddr(`REG_CTRL), {32'(takeBits(32)), ctrl}, rd);
		waitIdle();
		busAccess(opRead, regAddr(`REG_DATA), 64'h0, rd);
		checkValue("single byte read", rd, {56'h0, cardByte});
		checkValue("bytes at card", card0.mosiLog.size(), 1);
		if (card0.mosiLog.size() > 0)
			checkValue("byte at card", card0.mosiLog[0], txByte);
		checkRisePeriods(div);
		checkValue("chip select pin", spiCs, csBit);
	endtask

	task automatic burstTest();
		logic [63:0] sendWord;
		logic [63:0] cardWord;
		logic [31:0] ctrl;
		logic [63:0] rd;
		sendWord = takeBits(64);
		cardWord = takeBits(64);
		ctrl = {4'h0, 4'(takeBits(4)), 18'(takeBits(18)), 1'b1, 3'(takeBits(3)), 2'b00};
		card0.clearLogs();
		// card answers low byte first
		for (int i = 0; i < 8; i++)
			card0.queueByte(cardWord[8 * i +: 8]);
		busAccess(opWrite, regAddr(`REG_QUEUE), sendWord, rd);
		expCtrl = ctrl;
		busAccess(opWrite, regAddr(`REG_CTRL), {32'h0, ctrl}, rd);
		waitIdle();
		busAccess(opRead, regAddr(`REG_QUEUE), 64'h0, rd);
		expQueue = cardWord;
		checkValue("burst queue read", rd, expQueue);
		checkValue("burst bytes at card", card0.mosiLog.size(), 8);
		for (int i = 0; i < card0.mosiLog.size() && i < 8; i++)
			checkValue("burst byte at card", card0.mosiLog[i], sendWord[8 * i +: 8]);
	endtask

	// drive a request that must never be answered
	task automatic probeUnaddressed(input mmioOp op, input logic [31:0] addr,
		input logic [63:0] data);
		@(negedge clock);
		mmioAddr = addr;
		mmioInData = data;
		mmioOpm = op;
		repeat (6)
		begin
			@(negedge clock);
			checkValue("unaddressed response code", mmioOK, ready);
			checkValue("unaddressed read data", mmioOutData, 64'h0);
		end
		mmioOpm = opNone;
		repeat (3) @(negedge clock);
	endtask

	task automatic unaddressedTest();
		logic [11:0] wrongSel;
		logic [11:0] highBits;
		logic [63:0] rd;
		wrongSel = selfAddr ^ (12'(takeBits(12)) | 12'h001);
		highBits = 12'(takeBits(12)) | 12'h001;
		card0.clearLogs();
		// start bits set, so a decode slip would also show on the pins
		// a stray burst would also overwrite the receive queue
		probeUnaddressed(opWrite, {4'h0, 12'h000, wrongSel, `REG_CTRL, 2'b00}, 64'h0F00_0020);
		probeUnaddressed(opWrite, {4'h0, highBits, selfAddr, `REG_CTRL, 2'b00}, 64'h0300_0023);
		probeUnaddressed(opRead, {4'h0, highBits, selfAddr, `REG_QUEUE, 2'b00}, 64'h0);
		probeUnaddressed(opRead, {4'h0, 12'h000, wrongSel, `REG_CTRL, 2'b00}, 64'h0);
		busAccess(opRead, regAddr(`REG_CTRL), 64'h0, rd);
		checkValue("control after unaddressed requests", rd, {32'h0, expCtrl});
		busAccess(opRead, regAddr(`REG_QUEUE), 64'h0, rd);
		checkValue("queue after unaddressed requests", rd, expQueue);
		checkValue("bytes at card after unaddressed requests", card0.mosiLog.size(), 0);
	endtask

	task automatic busyTest();
		logic [63:0] rd;
		logic [31:0] newCtrl;
		logic [7:0] lastByte;
		lastByte = 8'(takeBits(8));
		card0.clearLogs();
		for (int i = 0; i < 7; i++)
			card0.queueByte(8'(takeBits(8)));
		card0.queueByte(lastByte);
		// burst at divider 2, CS low
		busAccess(opWrite, regAddr(`REG_CTRL), 64'h0200_0020, rd);
		busAccess(opRead, regAddr(`REG_CTRL), 64'h0, rd);
		checkValue("status during burst", rd, 64'h0200_0022);
		// held until all eight bytes are out
		busAccess(opRead, regAddr(`REG_DATA), 64'h0, rd);
		checkValue("bytes done before data read completed", card0.mosiLog.size(), 8);
		checkValue("data read after burst", rd, {56'h0, lastByte});
		// single byte, then a control write that has to wait for it
		card0.clearLogs();
		card0.queueByte(8'(takeBits(8)));
		busAccess(opWrite, regAddr(`REG_CTRL), 64'h0100_0002, rd);
		newCtrl = {8'h03, 16'(takeBits(16)), 3'b000, 3'(takeBits(3)), 2'b01};
		busAccess(opWrite, regAddr(`REG_CTRL), {32'h0, newCtrl}, rd);
		checkValue("bytes done before control write completed", card0.mosiLog.size(), 1);
		expCtrl = newCtrl;
		busAccess(opRead, regAddr(`REG_CTRL), 64'h0, rd);
		checkValue("control after held write", rd, {32'h0, expCtrl});
		checkValue("chip select after held write", spiCs, 1'b1);
	endtask

	initial
	begin
		logic [63:0] rd;
		errors = 0;
		checks = 0;
		lfsrState = 32'h59e65e08;
		mmioInData = '0;
		mmioAddr = '0;
		mmioOpm = opNone;
		mmioSelfAddr = selfAddr;
		expCtrl = 32'h0000_0001;
		expQueue = '0;
		@(negedge reset);
		card0.clearLogs();
		repeat (2) @(negedge clock);
		// reset state of pins and control
		checkValue("chip select after reset", spiCs, 1'b1);
		checkValue("SCLK after reset", spiSclk, 1'b0);
		busAccess(opRead, regAddr(`REG_CTRL), 64'h0, rd);
		checkValue("control after reset", rd, 64'h1);
		for (int i = 0; i < numSingles; i++)
			singleTest();
		for (int i = 0; i < numBursts; i++)
			burstTest();
		unaddressedTest();
		busyTest();
		errors += dut0.chk0.assertFails;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			dut0.chk0.assertFails);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// every byte at the slowest divider, plus reset and bus traffic
	initial
	begin
		#(longint'(numBytes) * byteCycles * clkPeriod + 200000);
		$display("watchdog expired, the test sequence did not finish in time");
		$display("tests failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+hw
hw/sdSpiPkg.sv
hw/spiEngineIf.sv
hw/mmioSpiRegs.sv
hw/spiBitEngine.sv
hw/sdSpiTop.sv
verification/clockGen.sv
verification/spiCardModel.sv
verification/sdSpiChk.sv
verification/sdSpiTb.sv
